/* source/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath word size, also the RAM word
`define DATA_WIDTH 32

// Register file depth, window arithmetic wraps at this size
`define REG_COUNT 64

// Arithmetic lanes, Vadd uses all of them
`define LANE_COUNT 4

`define RESET_WINDOW 2  // Window base after reset

// Absolute register holding the compare flag in bit 0
`define FLAG_REG 1

`endif

/* source/isaPkg.sv */
package isaPkg;

  // Instruction opcodes, low byte of every instruction word
  typedef enum logic [7:0] {
    Nop    = 8'h00,
    Add    = 8'h01,
    Sub    = 8'h02,
    Mul    = 8'h03,  // Low word of the product
    Min    = 8'h04,
    Max    = 8'h05,
    Cmp    = 8'h06,  // Equality test into the flag register
    Vadd   = 8'h07,  // Four-wide add over consecutive registers
    Ldi    = 8'h10,
    St     = 8'h11,
    SetWin = 8'h12,
    Jmp    = 8'h20,
    Jz     = 8'h21,
    Jnz    = 8'h22,
    Je     = 8'h23,  // Taken on flag set
    Jne    = 8'h24,  // Taken on flag clear
    Halt   = 8'h2F
  } opCode;

  // Register field
  // Values of 64 and up pick absolute register field - 64
  // Smaller values pick field + window base, modulo the register count
  typedef logic [7:0] regField;

  // Three-register form for arithmetic and store
  typedef struct packed {
    regField srcB;
    regField srcA;
    regField dest;
    opCode   op;
  } regFormat;

  // Constant form for Ldi, SetWin and the jumps, targets are byte addresses
  typedef struct packed {
    regField     regSel;    // Ldi destination, Jz/Jnz test register
    logic [15:0] constant;  // Zero extended on use
    opCode       op;
  } immFormat;

  typedef union packed {
    regFormat regForm;
    immFormat immForm;
  } instrWord;

endpackage

/* source/corePkg.sv */
package corePkg;

  // Sequencer steps, one instruction per pass from Fetch to Writeback
  typedef enum logic [2:0] {
    Fetch,      // readReq high
    Wait,       // RAM latency
    Decode,     // Instruction word sampled
    Operand,    // Lane issue
    Execute,    // Lane results valid
    Writeback,  // Register writes, next ipointer
    Halted
  } seqState;

  // Operation applied by every enabled lane
  typedef enum logic [2:0] {
    PassB,  // Operand B straight through, Ldi
    Add,
    Sub,
    Mul,
    Min,    // Signed compare
    Max,
    Eq      // 1 on equal operands, else 0
  } laneOp;

endpackage

/* source/laneBus.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

// Operands, operation and results shared by sequencer, register file, lanes and collector
interface laneBus;

  corePkg::laneOp              op;
  logic [`LANE_COUNT-1:0]      laneEnable;  // One bit per lane
  logic                        issue;       // Single cycle, Operand step

  logic [`DATA_WIDTH-1:0]      operandA [`LANE_COUNT];
  logic [`DATA_WIDTH-1:0]      operandB [`LANE_COUNT];

  // Driven one element per lane instance
  logic [`DATA_WIDTH-1:0]      result [`LANE_COUNT];
  logic                        valid [`LANE_COUNT];

  // Sequencer side, lane 0 operand A doubles as the store address
  modport control (output op, laneEnable, issue, input operandA);

  modport feeder (input op, output operandA, operandB);

  modport lane (input op, laneEnable, issue, operandA, operandB, output result, valid);

  modport drain (input op, result, valid);

endinterface

/* source/instructionSequencer.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module instructionSequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  isaPkg::instrWord       ramIn,       // Valid two cycles after readReq
  output logic [`DATA_WIDTH-1:0] ramAddress,  // Word address
  output logic [`DATA_WIDTH-1:0] ramOut,
  output logic                   readReq,
  output logic                   writeReq,
  output logic                   halted,
  output isaPkg::regField        destReg,     // Absolute register numbers
  output isaPkg::regField        srcAReg,
  output isaPkg::regField        srcBReg,
  output logic [`DATA_WIDTH-1:0] immediate,
  input  logic [`DATA_WIDTH-1:0] branchValue, // Jz/Jnz test register
  input  logic [`DATA_WIDTH-1:0] storeValue,
  input  logic                   flag,
  laneBus.control                lanes
);

  localparam int REG_BITS = $clog2(`REG_COUNT);

  corePkg::seqState       state;
  isaPkg::opCode          opReg;       // Opcode of the instruction in flight
  logic [`DATA_WIDTH-1:0] ipointer;    // Byte address
  logic [REG_BITS-1:0]    windowBase;
  corePkg::laneOp         decodedOp;
  logic [`LANE_COUNT-1:0] decodedEnable;
  logic                   usesImm;
  logic                   jumpTaken;
  logic [`DATA_WIDTH-1:0] nextIp;

  // Window rule from isaPkg
  function automatic isaPkg::regField mapField(input isaPkg::regField field,
                                               input logic [REG_BITS-1:0] base);
    if (field >= `REG_COUNT)
      return isaPkg::regField'((field - `REG_COUNT) % `REG_COUNT);  // Absolute
    return isaPkg::regField'((field + base) % `REG_COUNT);           // Window relative
  endfunction

  // Lane operation and lane mask straight off the fetched word
  always_comb
  begin
    case (ramIn.regForm.op)
      isaPkg::Add, isaPkg::Vadd: decodedOp = corePkg::Add;
      isaPkg::Sub:               decodedOp = corePkg::Sub;
      isaPkg::Mul:               decodedOp = corePkg::Mul;
      isaPkg::Min:               decodedOp = corePkg::Min;
      isaPkg::Max:               decodedOp = corePkg::Max;
      isaPkg::Cmp:               decodedOp = corePkg::Eq;
      default:                   decodedOp = corePkg::PassB;  // Ldi, unused by the rest
    endcase
    case (ramIn.regForm.op)
      isaPkg::Vadd:
        decodedEnable = '1;
      isaPkg::Add, isaPkg::Sub, isaPkg::Mul, isaPkg::Min, isaPkg::Max, isaPkg::Cmp, isaPkg::Ldi:
        decodedEnable = `LANE_COUNT'(1);
      default:
        decodedEnable = '0;  // Nop, St, SetWin, jumps, Halt
    endcase
    usesImm = ramIn.regForm.op inside {isaPkg::Ldi, isaPkg::SetWin, isaPkg::Jmp,
                                       isaPkg::Jz, isaPkg::Jnz, isaPkg::Je, isaPkg::Jne};
  end

  // Branch resolution, flag and test register are current by Writeback
  always_comb
  begin
    case (opReg)
      isaPkg::Jmp: jumpTaken = 1'b1;
      isaPkg::Jz:  jumpTaken = (branchValue == '0);
      isaPkg::Jnz: jumpTaken = (branchValue != '0);
      isaPkg::Je:  jumpTaken = flag;
      isaPkg::Jne: jumpTaken = !flag;
      default:     jumpTaken = 1'b0;
    endcase
    nextIp = jumpTaken ? immediate : ipointer + 4;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state            <= corePkg::Fetch;
      ipointer         <= '0;
      windowBase       <= REG_BITS'(`RESET_WINDOW);
      readReq          <= 1'b0;
      writeReq         <= 1'b0;
      halted           <= 1'b0;
      lanes.issue      <= 1'b0;
      lanes.laneEnable <= '0;
    end
    else
    begin
      case (state)
        corePkg::Fetch:
        begin
          if (readReq)
          begin
            readReq <= 1'b0;  // Strobe was armed at the previous Writeback
            state   <= corePkg::Wait;
          end
          else
          begin
            // First fetch after reset, arm the strobe and come back
            readReq    <= 1'b1;
            ramAddress <= ipointer >> 2;
          end
        end
        corePkg::Wait:
          state <= corePkg::Decode;
        corePkg::Decode:
        begin
          opReg     <= ramIn.regForm.op;
          immediate <= `DATA_WIDTH'(ramIn.immForm.constant);
          destReg   <= usesImm ? mapField(ramIn.immForm.regSel, windowBase)
                               : mapField(ramIn.regForm.dest, windowBase);
          srcAReg   <= mapField(ramIn.regForm.srcA, windowBase);
          srcBReg   <= mapField(ramIn.regForm.srcB, windowBase);
          lanes.op         <= decodedOp;
          lanes.laneEnable <= decodedEnable;
          lanes.issue      <= 1'b1;
          state            <= corePkg::Operand;
        end
        corePkg::Operand:
        begin
          lanes.issue <= 1'b0;
          state       <= corePkg::Execute;
        end
        corePkg::Execute:
        begin
          if (opReg == isaPkg::St)
          begin
            writeReq   <= 1'b1;                // High through Writeback
            ramAddress <= lanes.operandA[0];  // Source A register holds the word address
            ramOut     <= storeValue;
          end
          state <= corePkg::Writeback;
        end
        corePkg::Writeback:
        begin
          writeReq <= 1'b0;
          if (opReg == isaPkg::Halt)
          begin
            halted <= 1'b1;
            state  <= corePkg::Halted;
          end
          else
          begin
            if (opReg == isaPkg::SetWin)
              windowBase <= immediate[REG_BITS-1:0];
            ipointer   <= nextIp;
            ramAddress <= nextIp >> 2;  // Next fetch strobe goes out with Fetch
            readReq    <= 1'b1;
            state      <= corePkg::Fetch;
          end
        end
        corePkg::Halted:
          state <= corePkg::Halted;  // Only reset leaves
        default:
          state <= corePkg::Fetch;
      endcase
    end
  end

  // Store strobe and fetch strobe share ramAddress
  noReadWriteOverlap: assert property (@(posedge clk) disable iff (reset)
    !(readReq && writeReq));

endmodule

/* source/registerWindow.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module registerWindow (
  input  logic                         clk,
  input  logic                         reset,
  input  isaPkg::regField              srcAReg,
  input  isaPkg::regField              srcBReg,
  input  isaPkg::regField              destReg,
  input  logic [`DATA_WIDTH-1:0]       immediate,   // Operand B for Ldi
  input  logic [`LANE_COUNT-1:0]       writeMask,
  input  isaPkg::regField              writeBase,   // Lane i writes writeBase + i
  input  logic [`DATA_WIDTH-1:0]       writeData [`LANE_COUNT],
  output logic [`DATA_WIDTH-1:0]       branchValue,
  output logic [`DATA_WIDTH-1:0]       storeValue,
  output logic                         flag,
  input  logic [$clog2(`REG_COUNT)-1:0] debugAddress,
  output logic [`DATA_WIDTH-1:0]       debugData,
  laneBus.feeder                       lanes
);

  localparam int REG_BITS = $clog2(`REG_COUNT);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  // Register number plus lane offset, wrapped
  function automatic logic [REG_BITS-1:0] wrapReg(input isaPkg::regField base, input int offset);
    return REG_BITS'((base + offset) % `REG_COUNT);
  endfunction

  // Lane i sees registers srcA + i and srcB + i
  always_comb
  begin
    for (int i = 0; i < `LANE_COUNT; i++)
    begin
      lanes.operandA[i] = regs[wrapReg(srcAReg, i)];
      lanes.operandB[i] = (lanes.op == corePkg::PassB) ? immediate : regs[wrapReg(srcBReg, i)];
    end
  end

  assign branchValue = regs[wrapReg(destReg, 0)];
  assign storeValue  = regs[wrapReg(srcBReg, 0)];
  assign flag        = regs[`FLAG_REG][0];
  assign debugData   = regs[debugAddress];  // Combinational peek

  // Up to four writes in the Writeback cycle
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < `LANE_COUNT; i++)
      begin
        if (writeMask[i])
          regs[wrapReg(writeBase, i)] <= writeData[i];
      end
    end
  end

  // Collector only ever targets a real register
  writeBaseInRange: assert property (@(posedge clk) disable iff (reset)
    (writeMask != '0) |-> (writeBase < `REG_COUNT));

endmodule

/* source/vectorLane.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module vectorLane #(
  parameter int laneIndex = 0  // Position in the lane array
) (
  input  logic clk,
  input  logic reset,
  laneBus.lane lanes
);

  logic [`DATA_WIDTH-1:0] operandA;
  logic [`DATA_WIDTH-1:0] operandB;
  logic [`DATA_WIDTH-1:0] aluOut;
  logic [`DATA_WIDTH-1:0] resultReg;
  logic                   validReg;
  logic                   start;

  assign operandA = lanes.operandA[laneIndex];
  assign operandB = lanes.operandB[laneIndex];
  assign start    = lanes.issue && lanes.laneEnable[laneIndex];

  always_comb
  begin
    case (lanes.op)
      corePkg::Add: aluOut = operandA + operandB;
      corePkg::Sub: aluOut = operandA - operandB;
      corePkg::Mul: aluOut = operandA * operandB;  // Upper half dropped
      corePkg::Min: aluOut = ($signed(operandA) < $signed(operandB)) ? operandA : operandB;
      corePkg::Max: aluOut = ($signed(operandA) > $signed(operandB)) ? operandA : operandB;
      corePkg::Eq:  aluOut = `DATA_WIDTH'(operandA == operandB);
      default:      aluOut = operandB;             // PassB
    endcase
  end

  // Result lands one cycle after issue
  always_ff @(posedge clk)
  begin
    if (reset)
      validReg <= 1'b0;
    else
      validReg <= start;  // One cycle pulse, issue never stays high
  end

  always_ff @(posedge clk)
  begin
    if (start)
      resultReg <= aluOut;
  end

  assign lanes.result[laneIndex] = resultReg;
  assign lanes.valid[laneIndex]  = validReg;

  // Issue lasts one cycle, so valid never spills into Writeback
  issueSinglePulse: assert property (@(posedge clk) disable iff (reset)
    lanes.issue |=> !lanes.issue);

endmodule

/* source/laneCollector.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module laneCollector (
  input  logic                   clk,
  input  logic                   reset,
  input  isaPkg::regField        destReg,
  laneBus.drain                  lanes,
  output logic [`LANE_COUNT-1:0] writeMask,  // High for the Writeback cycle only
  output isaPkg::regField        writeBase,
  output logic [`DATA_WIDTH-1:0] writeData [`LANE_COUNT]
);

  logic isCompare;

  assign isCompare = (lanes.op == corePkg::Eq);

  // Valid bits from Execute become the write mask in Writeback
  always_ff @(posedge clk)
  begin
    if (reset)
      writeMask <= '0;
    else
    begin
      for (int i = 0; i < `LANE_COUNT; i++)
        writeMask[i] <= lanes.valid[i];
    end
  end

  // Target and data, meaningful only under the mask
  always_ff @(posedge clk)
  begin
    if (isCompare)
      writeBase <= isaPkg::regField'(`FLAG_REG);  // Compare lands in the flag register
    else
      writeBase <= destReg;
    for (int i = 0; i < `LANE_COUNT; i++)
    begin
      if (isCompare)
        writeData[i] <= `DATA_WIDTH'(lanes.result[i][0]);  // Flag in bit 0, rest zero
      else
        writeData[i] <= lanes.result[i];
    end
  end

endmodule

/* source/phaethonCore.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module phaethonCore (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`DATA_WIDTH-1:0]        ramIn,
  output logic [`DATA_WIDTH-1:0]        ramAddress,
  output logic [`DATA_WIDTH-1:0]        ramOut,
  output logic                          readReq,
  output logic                          writeReq,
  output logic                          halted,
  input  logic [$clog2(`REG_COUNT)-1:0] debugAddress,
  output logic [`DATA_WIDTH-1:0]        debugData
);

  isaPkg::regField        destReg;
  isaPkg::regField        srcAReg;
  isaPkg::regField        srcBReg;
  isaPkg::regField        writeBase;
  logic [`DATA_WIDTH-1:0] immediate;
  logic [`DATA_WIDTH-1:0] branchValue;
  logic [`DATA_WIDTH-1:0] storeValue;
  logic                   flag;
  logic [`LANE_COUNT-1:0] writeMask;
  logic [`DATA_WIDTH-1:0] writeData [`LANE_COUNT];

  laneBus lanes ();  // Shared by all four blocks

  instructionSequencer sequencer (
    .clk, .reset, .ramIn, .ramAddress, .ramOut,
    .readReq, .writeReq, .halted,
    .destReg, .srcAReg, .srcBReg, .immediate,
    .branchValue, .storeValue, .flag,
    .lanes (lanes)
  );

  registerWindow regFile (
    .clk, .reset, .srcAReg, .srcBReg, .destReg, .immediate,
    .writeMask, .writeBase, .writeData,
    .branchValue, .storeValue, .flag,
    .debugAddress, .debugData,
    .lanes (lanes)
  );

  // One lane per vector element
  for (genvar i = 0; i < `LANE_COUNT; i++)
  begin : laneGen
    vectorLane #(.laneIndex(i)) lane (
      .clk, .reset,
      .lanes (lanes)
    );
  end

  laneCollector collector (
    .clk, .reset, .destReg,
    .lanes (lanes),
    .writeMask, .writeBase, .writeData
  );

endmodule

/* verification/programRam.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

// Program memory model, two cycle read latency and a store capture
module programRam #(
  parameter int depth = 256
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   readReq,
  input  logic                   writeReq,
  input  logic [`DATA_WIDTH-1:0] ramAddress,        // Word address
  input  logic [`DATA_WIDTH-1:0] ramOut,
  output logic [`DATA_WIDTH-1:0] ramIn,
  output int                     fetchCount,
  output int                     writeCount,
  output logic [`DATA_WIDTH-1:0] lastWriteAddress,
  output logic [`DATA_WIDTH-1:0] lastWriteData
);

  localparam int ADDR_BITS = $clog2(depth);

  logic [`DATA_WIDTH-1:0] mem [depth];  // Loaded by the testbench
  logic [`DATA_WIDTH-1:0] readStage;
  logic                   readPending;

  // First cycle latches the word, second cycle presents it
  always_ff @(posedge clk)
  begin
    if (reset)
      readPending <= 1'b0;
    else
      readPending <= readReq;
    if (readReq)
      readStage <= mem[ramAddress[ADDR_BITS-1:0]];
    if (readPending)
      ramIn <= readStage;  // Held until the next read
  end

  // Strobe counters and the last store seen
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      fetchCount <= 0;
      writeCount <= 0;
    end
    else
    begin
      if (readReq)
        fetchCount <= fetchCount + 1;
      if (writeReq)
      begin
        writeCount       <= writeCount + 1;
        lastWriteAddress <= ramAddress;
        lastWriteData    <= ramOut;
      end
    end
  end

endmodule

/* verification/phaethonCoreTb.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module phaethonCoreTb;

  localparam int RAM_DEPTH    = 256;
  localparam int RESET_CYCLES = 8;
  localparam int TEST_COUNT   = 5;
  localparam int LONGEST_PROG = 22;   // Branch program
  localparam int MARGIN       = 100;  // Register reads, halt watch, final reset
  localparam int CYCLE_LIMIT  = TEST_COUNT * (6 * LONGEST_PROG + RESET_CYCLES + MARGIN);

  logic                          clk;
  logic                          reset;
  logic [`DATA_WIDTH-1:0]        ramIn;
  logic [`DATA_WIDTH-1:0]        ramAddress;
  logic [`DATA_WIDTH-1:0]        ramOut;
  logic                          readReq;
  logic                          writeReq;
  logic                          halted;
  logic [$clog2(`REG_COUNT)-1:0] debugAddress;
  logic [`DATA_WIDTH-1:0]        debugData;
  int                            fetchCount;
  int                            writeCount;
  logic [`DATA_WIDTH-1:0]        lastWriteAddress;
  logic [`DATA_WIDTH-1:0]        lastWriteData;

  int seed          = 82491;
  int mismatchCount = 0;
  int otherCount    = 0;  // Failures that are not a value mismatch
  int cycleCount    = 0;
  int programLength = 0;

  phaethonCore DUT (
    .clk, .reset, .ramIn, .ramAddress, .ramOut,
    .readReq, .writeReq, .halted,
    .debugAddress, .debugData
  );

  programRam #(.depth(RAM_DEPTH)) ram (
    .clk, .reset, .readReq, .writeReq, .ramAddress, .ramOut, .ramIn,
    .fetchCount, .writeCount, .lastWriteAddress, .lastWriteData
  );

  always #50 clk = ~clk;  // 100 ns period

  // Run limit over all tests
  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT)
    begin
      $display("Timeout: core did not finish the tests within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // Field value for an absolute register
  function automatic isaPkg::regField absoluteField(input int regNum);
    return isaPkg::regField'(`REG_COUNT + regNum);
  endfunction

  function automatic logic [15:0] byteAddr(input int index);
    return 16'(4 * index);  // Jump targets are byte addresses
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] regInstr(input isaPkg::opCode op,
    input isaPkg::regField dest, input isaPkg::regField srcA, input isaPkg::regField srcB);
    isaPkg::instrWord word;
    word.regForm.op   = op;
    word.regForm.dest = dest;
    word.regForm.srcA = srcA;
    word.regForm.srcB = srcB;
    return word;
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] immInstr(input isaPkg::opCode op,
    input isaPkg::regField regSel, input logic [15:0] constant);
    isaPkg::instrWord word;
    word.immForm.op       = op;
    word.immForm.regSel   = regSel;
    word.immForm.constant = constant;
    return word;
  endfunction

  task automatic compareWord(input string testName, input string label,
    input logic [`DATA_WIDTH-1:0] expected, input logic [`DATA_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      mismatchCount++;
      $display("mismatch test=%s %s expected=%h actual=%h", testName, label, expected, actual);
    end
  endtask

  task automatic compareBit(input string testName, input string label,
    input logic expected, input logic actual);
    if (actual !== expected)
    begin
      mismatchCount++;
      $display("mismatch test=%s %s expected=%b actual=%b", testName, label, expected, actual);
    end
  endtask

  task automatic compareStore(input string testName,
    input logic [`DATA_WIDTH-1:0] expAddress, input logic [`DATA_WIDTH-1:0] expData,
    input logic [`DATA_WIDTH-1:0] actAddress, input logic [`DATA_WIDTH-1:0] actData);
    if (actAddress !== expAddress)
    begin
      mismatchCount++;
      $display("mismatch test=%s store address expected=%h actual=%h",
               testName, expAddress, actAddress);
    end
    if (actData !== expData)
    begin
      mismatchCount++;
      $display("mismatch test=%s store data expected=%h actual=%h", testName, expData, actData);
    end
  endtask

  // Unused words decode as Halt, address in the upper bits
  task automatic startProgram();
    for (int i = 0; i < RAM_DEPTH; i++)
      ram.mem[i] = {24'(i), isaPkg::Halt};
    programLength = 0;
  endtask

  task automatic appendInstruction(input logic [`DATA_WIDTH-1:0] word);
    ram.mem[programLength] = word;
    programLength++;
  endtask

  task automatic pulseReset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic runProgram();
    pulseReset();
    @(negedge clk);
    while (!halted)
      @(negedge clk);
  endtask

  // Debug port is combinational, read mid cycle
  task automatic checkRegister(input string testName, input int regNum,
    input logic [`DATA_WIDTH-1:0] expected);
    @(posedge clk);
    debugAddress <= regNum[5:0];
    @(negedge clk);
    compareWord(testName, $sformatf("r%0d", regNum), expected, debugData);
  endtask

  task automatic testScalar();
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    logic [`DATA_WIDTH-1:0] diff;
    logic [`DATA_WIDTH-1:0] low;
    logic [`DATA_WIDTH-1:0] high;
    a    = $random(seed) & 32'h0000FFFF;
    b    = $random(seed) & 32'h0000FFFF;
    diff = a - b;                                            // May go negative
    low  = ($signed(diff) < $signed(a)) ? diff : a;          // Signed min
    high = ($signed(diff) > $signed(b)) ? diff : b;
    startProgram();
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(10), a[15:0]));
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(11), b[15:0]));
    appendInstruction(regInstr(isaPkg::Add, absoluteField(12), absoluteField(10), absoluteField(11)));
    appendInstruction(regInstr(isaPkg::Sub, absoluteField(13), absoluteField(10), absoluteField(11)));
    appendInstruction(regInstr(isaPkg::Mul, absoluteField(14), absoluteField(10), absoluteField(11)));
    appendInstruction(regInstr(isaPkg::Min, absoluteField(15), absoluteField(13), absoluteField(10)));
    appendInstruction(regInstr(isaPkg::Max, absoluteField(16), absoluteField(13), absoluteField(11)));
    appendInstruction(immInstr(isaPkg::Halt, 8'd0, 16'd0));
    runProgram();
    checkRegister("scalar", 10, a);
    checkRegister("scalar", 12, a + b);
    checkRegister("scalar", 13, diff);
    checkRegister("scalar", 14, a * b);  // Low word only
    checkRegister("scalar", 15, low);
    checkRegister("scalar", 16, high);
  endtask

  task automatic testVector();
    logic [`DATA_WIDTH-1:0] a [`LANE_COUNT];
    logic [`DATA_WIDTH-1:0] b [`LANE_COUNT];
    for (int i = 0; i < `LANE_COUNT; i++)
    begin
      a[i] = $random(seed) & 32'h0000FFFF;
      b[i] = $random(seed) & 32'h0000FFFF;
    end
    startProgram();
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(29), 16'h1234));  // Neighbor below
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(34), 16'h5678));  // Neighbor above
    for (int i = 0; i < `LANE_COUNT; i++)
    begin
      appendInstruction(immInstr(isaPkg::Ldi, absoluteField(20 + i), a[i][15:0]));
      appendInstruction(immInstr(isaPkg::Ldi, absoluteField(24 + i), b[i][15:0]));
    end
    appendInstruction(regInstr(isaPkg::Vadd, absoluteField(30), absoluteField(20), absoluteField(24)));
    appendInstruction(immInstr(isaPkg::Halt, 8'd0, 16'd0));
    runProgram();
    for (int i = 0; i < `LANE_COUNT; i++)
      checkRegister("vector", 30 + i, a[i] + b[i]);
    checkRegister("vector", 29, 32'h1234);
    checkRegister("vector", 34, 32'h5678);
  endtask

  task automatic testWindow();
    logic [`DATA_WIDTH-1:0] x [4];
    for (int i = 0; i < 4; i++)
      x[i] = $random(seed) & 32'h0000FFFF;
    startProgram();
    appendInstruction(immInstr(isaPkg::Ldi, 8'd0, x[0][15:0]));  // Window 2, lands in r2
    appendInstruction(immInstr(isaPkg::SetWin, 8'd0, 16'd40));
    appendInstruction(immInstr(isaPkg::Ldi, 8'd0, x[1][15:0]));  // r40
    appendInstruction(immInstr(isaPkg::Ldi, 8'd1, x[2][15:0]));  // r41
    appendInstruction(regInstr(isaPkg::Add, 8'd2, 8'd0, 8'd1));   // r42
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(5), x[3][15:0]));
    appendInstruction(regInstr(isaPkg::Add, absoluteField(6), absoluteField(2), 8'd0));
    appendInstruction(immInstr(isaPkg::Halt, 8'd0, 16'd0));
    runProgram();
    checkRegister("window", 2, x[0]);
    checkRegister("window", 40, x[1]);
    checkRegister("window", 41, x[2]);
    checkRegister("window", 42, x[1] + x[2]);
    checkRegister("window", 5, x[3]);
    checkRegister("window", 6, x[0] + x[1]);  // Absolute plus relative mix
    checkRegister("window", 3, 32'h0);
  endtask

  task automatic testBranch();
    logic [`DATA_WIDTH-1:0] v;
    v = ($random(seed) & 32'h0000FFFF) | 32'h00000100;  // Nonzero for Jz/Jnz
    startProgram();
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(10), v[15:0]));          // 0
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(11), v[15:0]));          // 1
    appendInstruction(regInstr(isaPkg::Cmp, absoluteField(30), absoluteField(10),
                               absoluteField(11)));                                 // 2 flag set
    appendInstruction(immInstr(isaPkg::Je, 8'd0, byteAddr(5)));                    // 3 taken
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(20), 16'hBAD1));         // 4
    appendInstruction(immInstr(isaPkg::Jne, 8'd0, byteAddr(7)));                   // 5 not taken
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(21), 16'h0001));         // 6
    appendInstruction(regInstr(isaPkg::Cmp, absoluteField(30), absoluteField(10),
                               absoluteField(24)));                                 // 7 flag clear
    appendInstruction(immInstr(isaPkg::Jne, 8'd0, byteAddr(10)));                  // 8 taken
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(22), 16'hBAD2));         // 9
    appendInstruction(immInstr(isaPkg::Je, 8'd0, byteAddr(12)));                   // 10 not taken
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(23), 16'h0002));         // 11
    appendInstruction(immInstr(isaPkg::Jz, absoluteField(24), byteAddr(14)));      // 12 r24 zero
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(25), 16'hBAD3));         // 13
    appendInstruction(immInstr(isaPkg::Jnz, absoluteField(24), byteAddr(16)));     // 14 not taken
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(26), 16'h0003));         // 15
    appendInstruction(immInstr(isaPkg::Jnz, absoluteField(10), byteAddr(18)));     // 16 taken
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(27), 16'hBAD4));         // 17
    appendInstruction(immInstr(isaPkg::Jz, absoluteField(10), byteAddr(20)));      // 18 not taken
    appendInstruction(immInstr(isaPkg::Jmp, 8'd0, byteAddr(21)));                  // 19
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(28), 16'hBAD5));         // 20
    appendInstruction(immInstr(isaPkg::Halt, 8'd0, 16'd0));                        // 21
    runProgram();
    checkRegister("branch", `FLAG_REG, 32'h0);  // Last compare unequal
    checkRegister("branch", 20, 32'h0);
    checkRegister("branch", 21, 32'h1);
    checkRegister("branch", 22, 32'h0);
    checkRegister("branch", 23, 32'h2);
    checkRegister("branch", 25, 32'h0);
    checkRegister("branch", 26, 32'h3);
    checkRegister("branch", 27, 32'h0);
    checkRegister("branch", 28, 32'h0);
  endtask

  task automatic testStoreHalt();
    logic [`DATA_WIDTH-1:0] address;
    logic [`DATA_WIDTH-1:0] data;
    int                     fetchesAtHalt;
    address = 32'h80 | ($random(seed) & 32'h7F);  // Clear of the program words
    data    = $random(seed) & 32'h0000FFFF;
    startProgram();
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(10), address[15:0]));
    appendInstruction(immInstr(isaPkg::Ldi, absoluteField(11), data[15:0]));
    appendInstruction(regInstr(isaPkg::St, absoluteField(0), absoluteField(10), absoluteField(11)));
    appendInstruction(immInstr(isaPkg::Halt, 8'd0, 16'd0));
    runProgram();
    if (writeCount != 1)
    begin
      otherCount++;
      $display("Store test: expected exactly one RAM write, saw %0d", writeCount);
    end
    compareStore("store", address, data, lastWriteAddress, lastWriteData);
    fetchesAtHalt = fetchCount;
    repeat (20) @(negedge clk);
    if (fetchCount != fetchesAtHalt)
    begin
      otherCount++;
      $display("Store test: core kept fetching after it halted");
    end
    compareBit("store", "halted held", 1'b1, halted);
    // Reset out of Halted clears the flag and the registers
    @(posedge clk);
    reset        <= 1'b1;
    debugAddress <= 6'd10;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    compareBit("reset", "halted", 1'b0, halted);
    compareWord("reset", "r10", 32'h0, debugData);
    // Rerun, then reset while the fetch after the store is on the bus
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    while (!writeReq)
      @(negedge clk);
    @(posedge clk);
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    compareBit("reset", "readReq", 1'b0, readReq);
    compareBit("reset", "writeReq", 1'b0, writeReq);
    @(posedge clk);
    reset <= 1'b0;
  endtask

  initial
  begin
    clk          = 1'b0;
    reset        = 1'b1;
    debugAddress = '0;
    testScalar();
    testVector();
    testWindow();
    testBranch();
    testStoreHalt();
    $display("Summary: %0d mismatches, %0d other errors", mismatchCount, otherCount);
    if (mismatchCount + otherCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* phaethonCore.f */
+incdir+source
source/isaPkg.sv
source/corePkg.sv
source/laneBus.sv
source/instructionSequencer.sv
source/registerWindow.sv
source/vectorLane.sv
source/laneCollector.sv
source/phaethonCore.sv
verification/programRam.sv
verification/phaethonCoreTb.sv
